// ==== flist.f ====
+incdir+include
source/uop_pkg.sv
source/station_pkg.sv
source/rs_bank.sv
source/dispatch_router.sv
source/issue_select.sv
source/reservation_station.sv
verification/tb_reservation_station.sv

// ==== include/rs_config.svh ====
`ifndef RS_CONFIG_SVH
`define RS_CONFIG_SVH

// entries per class of the reservation station

// alu entries
`define RS_ALU_ENTRIES 4

// multiply entries
`define RS_MULT_ENTRIES 2

// branch entries, issued only at the rob head
`define RS_BRANCH_ENTRIES 2

// physical register file
`define PREG_COUNT 64

// reorder buffer depth
`define ROB_SIZE 32

// instruction address width in bits
`define PC_WIDTH 32

`endif

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f flist.f --top-module tb_reservation_station -o sim_reservation_station

output="$(./obj_dir/sim_reservation_station)"
echo "$output"

if grep -qx "all tests passed" <<< "$output"; then
    exit 0
fi
exit 1

// ==== source/dispatch_router.sv ====
`timescale 1ns/1ps

module dispatch_router (
    input  logic                clock,
    input  logic                reset,
    input  logic                rollback,
    input  logic                allocate,
    input  uop_pkg::func_type_t alloc_type,
    input  logic                alu_full,
    input  logic                mult_full,
    input  logic                branch_full,
    output logic                alu_write,
    output logic                mult_write,
    output logic                branch_write,
    output logic                done
);
    import uop_pkg::*;

    // one strobe per class, held back when that class has no room
    assign alu_write = allocate && alloc_type == FUNC_ALU && !alu_full;
    assign mult_write = allocate && alloc_type == FUNC_MULT && !mult_full;
    assign branch_write = allocate && alloc_type == FUNC_BRANCH && !branch_full;

    // done answers the allocation one cycle later
    always_ff @(posedge clock) begin
        if (reset || rollback) begin
            done <= 1'b0;
        end else begin
            done <= alu_write || mult_write || branch_write;
        end
    end

    // the fourth encoding has no class behind it
    a_legal_type: assert property (
        @(posedge clock) disable iff (reset)
        allocate |-> alloc_type inside {FUNC_ALU, FUNC_MULT, FUNC_BRANCH}
    ) else $error("dispatch_router: illegal alloc_type %0d", alloc_type);

endmodule

// ==== source/issue_select.sv ====
`timescale 1ns/1ps

module issue_select (
    input  logic                clock,
    input  logic                reset,
    input  logic                rollback,
    input  logic                issue_enable,
    input  logic                alu_pick_valid,
    input  station_pkg::slot_t  alu_pick_slot,
    input  uop_pkg::pc_t        alu_pick_pc,
    input  uop_pkg::preg_t      alu_pick_dest,
    input  uop_pkg::rob_index_t alu_pick_rob,
    input  logic                mult_pick_valid,
    input  station_pkg::slot_t  mult_pick_slot,
    input  uop_pkg::pc_t        mult_pick_pc,
    input  uop_pkg::preg_t      mult_pick_dest,
    input  uop_pkg::rob_index_t mult_pick_rob,
    input  logic                branch_pick_valid,
    input  station_pkg::slot_t  branch_pick_slot,
    input  uop_pkg::pc_t        branch_pick_pc,
    input  uop_pkg::preg_t      branch_pick_dest,
    input  uop_pkg::rob_index_t branch_pick_rob,
    output logic                alu_grant,
    output logic                mult_grant,
    output logic                branch_grant,
    output logic                issue_valid,
    output uop_pkg::func_type_t issue_type,
    output station_pkg::slot_t  issue_slot,
    output uop_pkg::pc_t        issue_pc,
    output uop_pkg::preg_t      issue_dest,
    output uop_pkg::rob_index_t issue_rob
);
    import uop_pkg::*;
    import station_pkg::*;

    bank_sel_t grant;

    // fixed priority, alu first and branch last
    always_comb begin
        grant = '0;
        if (issue_enable) begin
            if (alu_pick_valid) begin
                grant[BANK_ALU] = 1'b1;
            end else if (mult_pick_valid) begin
                grant[BANK_MULT] = 1'b1;
            end else if (branch_pick_valid) begin
                grant[BANK_BRANCH] = 1'b1;
            end
        end
    end

    assign alu_grant = grant[BANK_ALU];
    assign mult_grant = grant[BANK_MULT];
    assign branch_grant = grant[BANK_BRANCH];

    always_ff @(posedge clock) begin
        if (reset || rollback) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= |grant;
        end
    end

    // issue fields, meaningful only with issue_valid
    always_ff @(posedge clock) begin
        if (grant[BANK_ALU]) begin
            issue_type <= FUNC_ALU;
            issue_slot <= alu_pick_slot;
            issue_pc <= alu_pick_pc;
            issue_dest <= alu_pick_dest;
            issue_rob <= alu_pick_rob;
        end else if (grant[BANK_MULT]) begin
            issue_type <= FUNC_MULT;
            issue_slot <= mult_pick_slot;
            issue_pc <= mult_pick_pc;
            issue_dest <= mult_pick_dest;
            issue_rob <= mult_pick_rob;
        end else if (grant[BANK_BRANCH]) begin
            issue_type <= FUNC_BRANCH;
            issue_slot <= branch_pick_slot;
            issue_pc <= branch_pick_pc;
            issue_dest <= branch_pick_dest;
            issue_rob <= branch_pick_rob;
        end
    end

endmodule

// ==== source/reservation_station.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module reservation_station (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          allocate,
    input  uop_pkg::func_type_t           alloc_type,
    input  uop_pkg::pc_t                  alloc_pc,
    input  uop_pkg::preg_t                alloc_dest,
    input  uop_pkg::preg_t                alloc_src1,
    input  logic                          alloc_src1_ready,
    input  uop_pkg::preg_t                alloc_src2,
    input  logic                          alloc_src2_ready,
    input  uop_pkg::rob_index_t           alloc_rob,
    output logic                          done,
    input  logic                          update,
    input  uop_pkg::preg_t                ready_reg,
    input  logic                          issue_enable,
    output logic                          issue_valid,
    output uop_pkg::func_type_t           issue_type,
    output station_pkg::slot_t            issue_slot,
    output uop_pkg::pc_t                  issue_pc,
    output uop_pkg::preg_t                issue_dest,
    output uop_pkg::rob_index_t           issue_rob,
    input  uop_pkg::rob_index_t           rob_head,
    input  logic [`RS_ALU_ENTRIES-1:0]    free_alu,
    input  logic [`RS_MULT_ENTRIES-1:0]   free_mult,
    input  logic [`RS_BRANCH_ENTRIES-1:0] free_branch,
    input  logic                          rollback,
    output logic                          alu_full,
    output logic                          mult_full,
    output logic                          branch_full
);
    import uop_pkg::*;
    import station_pkg::*;

    logic alu_write, mult_write, branch_write;
    logic alu_grant, mult_grant, branch_grant;

    // bank picks toward the selector
    logic       alu_pick_valid, mult_pick_valid, branch_pick_valid;
    slot_t      alu_pick_slot, mult_pick_slot, branch_pick_slot;
    pc_t        alu_pick_pc, mult_pick_pc, branch_pick_pc;
    preg_t      alu_pick_dest, mult_pick_dest, branch_pick_dest;
    rob_index_t alu_pick_rob, mult_pick_rob, branch_pick_rob;

    dispatch_router i_dispatch_router (
        .clock, .reset, .rollback, .allocate, .alloc_type,
        .alu_full, .mult_full, .branch_full,
        .alu_write, .mult_write, .branch_write, .done
    );

    rs_bank #(.ENTRIES(`RS_ALU_ENTRIES), .HEAD_ORDERED(1'b0)) alu_bank (
        .clock, .reset, .rollback, .write(alu_write),
        .pc(alloc_pc), .dest(alloc_dest), .src1(alloc_src1), .src1_ready(alloc_src1_ready),
        .src2(alloc_src2), .src2_ready(alloc_src2_ready), .rob(alloc_rob),
        .update, .ready_reg, .rob_head, .grant(alu_grant), .free_slots(free_alu),
        .full(alu_full), .pick_valid(alu_pick_valid), .pick_slot(alu_pick_slot),
        .pick_pc(alu_pick_pc), .pick_dest(alu_pick_dest), .pick_rob(alu_pick_rob)
    );

    rs_bank #(.ENTRIES(`RS_MULT_ENTRIES), .HEAD_ORDERED(1'b0)) mult_bank (
        .clock, .reset, .rollback, .write(mult_write),
        .pc(alloc_pc), .dest(alloc_dest), .src1(alloc_src1), .src1_ready(alloc_src1_ready),
        .src2(alloc_src2), .src2_ready(alloc_src2_ready), .rob(alloc_rob),
        .update, .ready_reg, .rob_head, .grant(mult_grant), .free_slots(free_mult),
        .full(mult_full), .pick_valid(mult_pick_valid), .pick_slot(mult_pick_slot),
        .pick_pc(mult_pick_pc), .pick_dest(mult_pick_dest), .pick_rob(mult_pick_rob)
    );

    // branches wait for the rob head
    rs_bank #(.ENTRIES(`RS_BRANCH_ENTRIES), .HEAD_ORDERED(1'b1)) branch_bank (
        .clock, .reset, .rollback, .write(branch_write),
        .pc(alloc_pc), .dest(alloc_dest), .src1(alloc_src1), .src1_ready(alloc_src1_ready),
        .src2(alloc_src2), .src2_ready(alloc_src2_ready), .rob(alloc_rob),
        .update, .ready_reg, .rob_head, .grant(branch_grant), .free_slots(free_branch),
        .full(branch_full), .pick_valid(branch_pick_valid), .pick_slot(branch_pick_slot),
        .pick_pc(branch_pick_pc), .pick_dest(branch_pick_dest), .pick_rob(branch_pick_rob)
    );

    issue_select i_issue_select (
        .clock, .reset, .rollback, .issue_enable,
        .alu_pick_valid, .alu_pick_slot, .alu_pick_pc, .alu_pick_dest, .alu_pick_rob,
        .mult_pick_valid, .mult_pick_slot, .mult_pick_pc, .mult_pick_dest, .mult_pick_rob,
        .branch_pick_valid, .branch_pick_slot, .branch_pick_pc, .branch_pick_dest,
        .branch_pick_rob,
        .alu_grant, .mult_grant, .branch_grant,
        .issue_valid, .issue_type, .issue_slot, .issue_pc, .issue_dest, .issue_rob
    );

endmodule

// ==== source/rs_bank.sv ====
`timescale 1ns/1ps

module rs_bank #(
    parameter int ENTRIES = 4,
    parameter bit HEAD_ORDERED = 1'b0
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                rollback,
    input  logic                write,
    input  uop_pkg::pc_t        pc,
    input  uop_pkg::preg_t      dest,
    input  uop_pkg::preg_t      src1,
    input  logic                src1_ready,
    input  uop_pkg::preg_t      src2,
    input  logic                src2_ready,
    input  uop_pkg::rob_index_t rob,
    input  logic                update,
    input  uop_pkg::preg_t      ready_reg,
    input  uop_pkg::rob_index_t rob_head,
    input  logic                grant,
    input  logic [ENTRIES-1:0]  free_slots,
    output logic                full,
    output logic                pick_valid,
    output station_pkg::slot_t  pick_slot,
    output uop_pkg::pc_t        pick_pc,
    output uop_pkg::preg_t      pick_dest,
    output uop_pkg::rob_index_t pick_rob
);
    import uop_pkg::*;
    import station_pkg::*;

    // per-entry control
    logic [ENTRIES-1:0] busy;
    logic [ENTRIES-1:0] issued;
    logic [ENTRIES-1:0] ready1;
    logic [ENTRIES-1:0] ready2;

    // per-entry payload
    preg_t      tag1 [ENTRIES];
    preg_t      tag2 [ENTRIES];
    preg_t      entry_dest [ENTRIES];
    pc_t        entry_pc [ENTRIES];
    rob_index_t entry_rob [ENTRIES];

    logic [ENTRIES-1:0] alloc_onehot;
    logic [ENTRIES-1:0] can_issue;
    logic [ENTRIES-1:0] pick_onehot;

    assign full = &busy;

    // lowest clear bit of busy
    assign alloc_onehot = ~busy & (busy + 1'b1);

    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            can_issue[i] = busy[i] && !issued[i] && ready1[i] && ready2[i]
                && (HEAD_ORDERED == 1'b0 || entry_rob[i] == rob_head);
        end
    end

    // highest ready slot wins, later iterations override
    always_comb begin
        pick_onehot = '0;
        pick_slot = '0;
        pick_pc = '0;
        pick_dest = '0;
        pick_rob = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (can_issue[i]) begin
                pick_onehot = '0;
                pick_onehot[i] = 1'b1;
                pick_slot = slot_t'(i);
                pick_pc = entry_pc[i];
                pick_dest = entry_dest[i];
                pick_rob = entry_rob[i];
            end
        end
    end

    assign pick_valid = |can_issue;

    always_ff @(posedge clock) begin
        if (reset || rollback) begin
            busy <= '0;
            issued <= '0;
        end else begin
            for (int i = 0; i < ENTRIES; i++) begin
                if (grant && pick_onehot[i]) begin
                    issued[i] <= 1'b1;
                end
                if (free_slots[i]) begin
                    busy[i] <= 1'b0;
                end
                if (write && alloc_onehot[i]) begin
                    busy[i] <= 1'b1;
                    issued[i] <= 1'b0;
                end
            end
        end
    end

    // wakeup and operand capture
    always_ff @(posedge clock) begin
        for (int i = 0; i < ENTRIES; i++) begin
            if (update && tag1[i] == ready_reg) begin
                ready1[i] <= 1'b1;
            end
            if (update && tag2[i] == ready_reg) begin
                ready2[i] <= 1'b1;
            end
            // a new entry keeps the ready bits it came with
            if (write && alloc_onehot[i]) begin
                tag1[i] <= src1;
                tag2[i] <= src2;
                ready1[i] <= src1_ready;
                ready2[i] <= src2_ready;
                entry_dest[i] <= dest;
                entry_pc[i] <= pc;
                entry_rob[i] <= rob;
            end
        end
    end

    // the router must hold writes back while the bank is full
    a_write_not_full: assert property (
        @(posedge clock) disable iff (reset) write |-> !full
    ) else $error("rs_bank: write while full");

    // the selector only grants a bank that offered an entry
    a_grant_has_pick: assert property (
        @(posedge clock) disable iff (reset) grant |-> pick_valid
    ) else $error("rs_bank: grant without pick_valid");

endmodule

// ==== source/station_pkg.sv ====
`include "rs_config.svh"

// types on the station side: slots within a bank and bank grants
package station_pkg;

    localparam int MAX_ENTRIES =
        (`RS_ALU_ENTRIES >= `RS_MULT_ENTRIES && `RS_ALU_ENTRIES >= `RS_BRANCH_ENTRIES) ?
            `RS_ALU_ENTRIES :
        (`RS_MULT_ENTRIES >= `RS_BRANCH_ENTRIES) ? `RS_MULT_ENTRIES : `RS_BRANCH_ENTRIES;

    // wide enough for the largest class
    localparam int SLOT_WIDTH = $clog2(MAX_ENTRIES);

    typedef logic [SLOT_WIDTH-1:0] slot_t;

    // bit positions in the grant vector, also the issue priority order
    localparam int BANK_ALU = 0;
    localparam int BANK_MULT = 1;
    localparam int BANK_BRANCH = 2;
    localparam int NUM_BANKS = 3;

    // one-hot over the classes
    typedef logic [NUM_BANKS-1:0] bank_sel_t;

endpackage

// ==== source/uop_pkg.sv ====
`include "rs_config.svh"

// types describing a dispatched micro-op
package uop_pkg;

    // register and rob index widths follow from their sizes
    localparam int PREG_WIDTH = $clog2(`PREG_COUNT);
    localparam int ROB_WIDTH = $clog2(`ROB_SIZE);

    // which functional unit class a micro-op goes to
    typedef enum logic [1:0] {
        FUNC_ALU = 2'd0,
        FUNC_MULT = 2'd1,
        FUNC_BRANCH = 2'd2
    } func_type_t;

    // physical register number
    typedef logic [PREG_WIDTH-1:0] preg_t;

    // reorder buffer index
    typedef logic [ROB_WIDTH-1:0] rob_index_t;

    // instruction address
    typedef logic [`PC_WIDTH-1:0] pc_t;

endpackage

// ==== verification/tb_reservation_station.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module tb_reservation_station;
    import uop_pkg::*;
    import station_pkg::*;

    // six tests take about this many cycles
    localparam int TEST_CYCLES = 400;
    localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;

    logic clock;
    logic reset;
    logic allocate;
    func_type_t alloc_type;
    pc_t alloc_pc;
    preg_t alloc_dest;
    preg_t alloc_src1;
    logic alloc_src1_ready;
    preg_t alloc_src2;
    logic alloc_src2_ready;
    rob_index_t alloc_rob;
    logic done;
    logic update;
    preg_t ready_reg;
    logic issue_enable;
    logic issue_valid;
    func_type_t issue_type;
    slot_t issue_slot;
    pc_t issue_pc;
    preg_t issue_dest;
    rob_index_t issue_rob;
    rob_index_t rob_head;
    logic [`RS_ALU_ENTRIES-1:0] free_alu;
    logic [`RS_MULT_ENTRIES-1:0] free_mult;
    logic [`RS_BRANCH_ENTRIES-1:0] free_branch;
    logic rollback;
    logic alu_full;
    logic mult_full;
    logic branch_full;

    // reference model state, indexed by class then slot
    logic [MAX_ENTRIES-1:0] m_busy [NUM_BANKS];
    logic [MAX_ENTRIES-1:0] m_issued [NUM_BANKS];
    logic [MAX_ENTRIES-1:0] m_ready1 [NUM_BANKS];
    logic [MAX_ENTRIES-1:0] m_ready2 [NUM_BANKS];
    preg_t m_tag1 [NUM_BANKS][MAX_ENTRIES];
    preg_t m_tag2 [NUM_BANKS][MAX_ENTRIES];
    preg_t m_dest [NUM_BANKS][MAX_ENTRIES];
    pc_t m_pc [NUM_BANKS][MAX_ENTRIES];
    rob_index_t m_rob [NUM_BANKS][MAX_ENTRIES];

    // predicted outputs
    logic exp_done;
    logic exp_issue_valid;
    func_type_t exp_issue_type;
    slot_t exp_issue_slot;
    pc_t exp_issue_pc;
    preg_t exp_issue_dest;
    rob_index_t exp_issue_rob;
    logic [2:0] exp_full;

    int error_count;
    int failed_tests;
    int cycle_count;
    logic [31:0] rng_state;

    reservation_station i_reservation_station (.*);

    initial begin : clock_gen
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    function automatic int class_size(input int c);
        case (c)
            BANK_ALU: return `RS_ALU_ENTRIES;
            BANK_MULT: return `RS_MULT_ENTRIES;
            default: return `RS_BRANCH_ENTRIES;
        endcase
    endfunction

    function automatic int class_of(input func_type_t t);
        case (t)
            FUNC_ALU: return BANK_ALU;
            FUNC_MULT: return BANK_MULT;
            default: return BANK_BRANCH;
        endcase
    endfunction

    function automatic func_type_t type_of(input int c);
        case (c)
            BANK_ALU: return FUNC_ALU;
            BANK_MULT: return FUNC_MULT;
            default: return FUNC_BRANCH;
        endcase
    endfunction

    function automatic logic [MAX_ENTRIES-1:0] free_of(input int c);
        case (c)
            BANK_ALU: return MAX_ENTRIES'(free_alu);
            BANK_MULT: return MAX_ENTRIES'(free_mult);
            default: return MAX_ENTRIES'(free_branch);
        endcase
    endfunction

    // busy, not issued, both operands ready, branches only at the rob head
    function automatic logic eligible(input int c, input int s);
        return m_busy[c][s] && !m_issued[c][s] && m_ready1[c][s] && m_ready2[c][s]
            && (c != BANK_BRANCH || m_rob[c][s] == rob_head);
    endfunction

    assign exp_full = {&m_busy[BANK_BRANCH][`RS_BRANCH_ENTRIES-1:0],
                       &m_busy[BANK_MULT][`RS_MULT_ENTRIES-1:0],
                       &m_busy[BANK_ALU][`RS_ALU_ENTRIES-1:0]};

    always @(posedge clock) begin : reference_model
        int pick [NUM_BANKS];
        int chosen;
        int target;
        int slot;
        logic [MAX_ENTRIES-1:0] freed;
        if (reset || rollback) begin
            for (int c = 0; c < NUM_BANKS; c++) begin
                m_busy[c] <= '0;
                m_issued[c] <= '0;
            end
            exp_done <= 1'b0;
            exp_issue_valid <= 1'b0;
        end else begin
            // highest eligible slot per class, then the first class in priority order
            chosen = -1;
            for (int c = 0; c < NUM_BANKS; c++) begin
                pick[c] = -1;
                for (int s = 0; s < class_size(c); s++) begin
                    if (eligible(c, s)) begin
                        pick[c] = s;
                    end
                end
                if (issue_enable && chosen < 0 && pick[c] >= 0) begin
                    chosen = c;
                end
            end
            exp_issue_valid <= chosen >= 0;
            if (chosen >= 0) begin
                exp_issue_type <= type_of(chosen);
                exp_issue_slot <= slot_t'(pick[chosen]);
                exp_issue_pc <= m_pc[chosen][pick[chosen]];
                exp_issue_dest <= m_dest[chosen][pick[chosen]];
                exp_issue_rob <= m_rob[chosen][pick[chosen]];
                m_issued[chosen][pick[chosen]] <= 1'b1;
            end
            for (int c = 0; c < NUM_BANKS; c++) begin
                freed = free_of(c);
                for (int s = 0; s < class_size(c); s++) begin
                    if (freed[s]) begin
                        m_busy[c][s] <= 1'b0;
                    end
                    if (update && m_tag1[c][s] == ready_reg) begin
                        m_ready1[c][s] <= 1'b1;
                    end
                    if (update && m_tag2[c][s] == ready_reg) begin
                        m_ready2[c][s] <= 1'b1;
                    end
                end
            end
            // lowest free slot of the class takes the new micro-op
            target = class_of(alloc_type);
            slot = -1;
            for (int s = class_size(target) - 1; s >= 0; s--) begin
                if (!m_busy[target][s]) begin
                    slot = s;
                end
            end
            exp_done <= allocate && slot >= 0;
            if (allocate && slot >= 0) begin
                m_busy[target][slot] <= 1'b1;
                m_issued[target][slot] <= 1'b0;
                m_ready1[target][slot] <= alloc_src1_ready;
                m_ready2[target][slot] <= alloc_src2_ready;
                m_tag1[target][slot] <= alloc_src1;
                m_tag2[target][slot] <= alloc_src2;
                m_dest[target][slot] <= alloc_dest;
                m_pc[target][slot] <= alloc_pc;
                m_rob[target][slot] <= alloc_rob;
            end
        end
    end

    task automatic report_mismatch(input string detail);
        error_count++;
        $display("** Error at %0t: %s", $time, detail);
    endtask

    a_done: assert property (@(posedge clock) disable iff (reset) done == exp_done)
        else report_mismatch($sformatf("done is %0h, expected %0h",
            $sampled(done), $sampled(exp_done)));
    a_full: assert property (@(posedge clock) disable iff (reset)
        {branch_full, mult_full, alu_full} == exp_full)
        else report_mismatch($sformatf("full flags {branch,mult,alu} are %b, expected %b",
            $sampled({branch_full, mult_full, alu_full}), $sampled(exp_full)));
    a_issue_valid: assert property (@(posedge clock) disable iff (reset)
        issue_valid == exp_issue_valid)
        else report_mismatch($sformatf("issue_valid is %0h, expected %0h",
            $sampled(issue_valid), $sampled(exp_issue_valid)));
    a_issue_type: assert property (@(posedge clock) disable iff (reset)
        exp_issue_valid |-> issue_type == exp_issue_type)
        else report_mismatch($sformatf("issue_type is %0d, expected %0d",
            $sampled(issue_type), $sampled(exp_issue_type)));
    a_issue_slot: assert property (@(posedge clock) disable iff (reset)
        exp_issue_valid |-> issue_slot == exp_issue_slot)
        else report_mismatch($sformatf("issue_slot is %0d, expected %0d",
            $sampled(issue_slot), $sampled(exp_issue_slot)));
    a_issue_pc: assert property (@(posedge clock) disable iff (reset)
        exp_issue_valid |-> issue_pc == exp_issue_pc)
        else report_mismatch($sformatf("issue_pc is %0h, expected %0h",
            $sampled(issue_pc), $sampled(exp_issue_pc)));
    a_issue_dest: assert property (@(posedge clock) disable iff (reset)
        exp_issue_valid |-> issue_dest == exp_issue_dest)
        else report_mismatch($sformatf("issue_dest is %0d, expected %0d",
            $sampled(issue_dest), $sampled(exp_issue_dest)));
    a_issue_rob: assert property (@(posedge clock) disable iff (reset)
        exp_issue_valid |-> issue_rob == exp_issue_rob)
        else report_mismatch($sformatf("issue_rob is %0d, expected %0d",
            $sampled(issue_rob), $sampled(exp_issue_rob)));

    always @(posedge clock) begin : watchdog
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    task automatic random_reg(output preg_t r);
        logic [31:0] value;
        draw(value);
        r = value[PREG_WIDTH-1:0];
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    // one allocation request, pc and dest drawn at random
    task automatic send_uop(input func_type_t t, input preg_t s1, input logic r1,
                            input preg_t s2, input logic r2, input rob_index_t rob);
        logic [31:0] value;
        draw(value);
        alloc_pc = value[`PC_WIDTH-1:0];
        draw(value);
        alloc_dest = value[PREG_WIDTH-1:0];
        alloc_type = t;
        alloc_src1 = s1;
        alloc_src1_ready = r1;
        alloc_src2 = s2;
        alloc_src2_ready = r2;
        alloc_rob = rob;
        allocate = 1'b1;
        next_cycle();
        allocate = 1'b0;
    endtask

    task automatic wait_done();
        while (!done) begin
            next_cycle();
        end
    endtask

    // enable issue until exactly one micro-op comes out
    task automatic wait_issue();
        issue_enable = 1'b1;
        next_cycle();
        while (!issue_valid) begin
            next_cycle();
        end
        issue_enable = 1'b0;
    endtask

    task automatic hold_issue(input int cycles);
        issue_enable = 1'b1;
        repeat (cycles) next_cycle();
        issue_enable = 1'b0;
    endtask

    task automatic flush_station();
        rollback = 1'b1;
        next_cycle();
        rollback = 1'b0;
    endtask

    task automatic finish_test(input int number, input string name, input int errors_before);
        // let the checks of the last cycle land
        next_cycle();
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", number, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", number, name, error_count - errors_before);
        end
    endtask

    initial begin : stimulus
        preg_t tag;
        preg_t other;
        rob_index_t rob;
        logic [31:0] value;
        int errors_before;
        $timeformat(-9, 0, " ns", 0);
        rng_state = 32'd17;
        error_count = 0;
        failed_tests = 0;
        cycle_count = 0;
        reset = 1'b1;
        allocate = 1'b0;
        alloc_type = FUNC_ALU;
        alloc_pc = '0;
        alloc_dest = '0;
        alloc_src1 = '0;
        alloc_src1_ready = 1'b0;
        alloc_src2 = '0;
        alloc_src2_ready = 1'b0;
        alloc_rob = '0;
        update = 1'b0;
        ready_reg = '0;
        issue_enable = 1'b0;
        rob_head = '0;
        free_alu = '0;
        free_mult = '0;
        free_branch = '0;
        rollback = 1'b0;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;

        errors_before = error_count;
        random_reg(tag);
        random_reg(other);
        send_uop(FUNC_ALU, tag, 1'b1, other, 1'b1, 5'd1);
        wait_done();
        wait_issue();
        finish_test(1, "alu allocate and issue", errors_before);

        flush_station();
        errors_before = error_count;
        repeat (`RS_MULT_ENTRIES) begin
            send_uop(FUNC_MULT, tag, 1'b1, other, 1'b1, 5'd2);
            wait_done();
        end
        // no room left, so this one is dropped
        send_uop(FUNC_MULT, tag, 1'b1, other, 1'b1, 5'd3);
        hold_issue(`RS_MULT_ENTRIES + 3);
        finish_test(2, "multiply full and drop", errors_before);

        flush_station();
        errors_before = error_count;
        random_reg(tag);
        send_uop(FUNC_ALU, tag, 1'b0, other, 1'b1, 5'd4);
        wait_done();
        hold_issue(3);
        update = 1'b1;
        ready_reg = tag + 1'b1;
        next_cycle();
        update = 1'b0;
        hold_issue(3);
        update = 1'b1;
        ready_reg = tag;
        next_cycle();
        update = 1'b0;
        wait_issue();
        finish_test(3, "operand wakeup", errors_before);

        flush_station();
        errors_before = error_count;
        draw(value);
        rob = value[ROB_WIDTH-1:0];
        rob_head = rob;
        send_uop(FUNC_BRANCH, tag, 1'b1, other, 1'b1, rob);
        send_uop(FUNC_MULT, tag, 1'b1, other, 1'b1, rob + 1'b1);
        send_uop(FUNC_ALU, tag, 1'b1, other, 1'b1, rob + 2'd2);
        // all three wait while issue is held off
        repeat (3) next_cycle();
        repeat (3) wait_issue();
        finish_test(4, "class priority", errors_before);

        flush_station();
        errors_before = error_count;
        draw(value);
        rob = value[ROB_WIDTH-1:0];
        rob_head = rob + 1'b1;
        send_uop(FUNC_BRANCH, tag, 1'b1, other, 1'b1, rob);
        wait_done();
        hold_issue(4);
        rob_head = rob;
        wait_issue();
        finish_test(5, "branch at rob head", errors_before);

        flush_station();
        errors_before = error_count;
        random_reg(tag);
        repeat (`RS_ALU_ENTRIES) begin
            send_uop(FUNC_ALU, tag, 1'b0, other, 1'b1, 5'd6);
        end
        free_alu[2] = 1'b1;
        next_cycle();
        free_alu = '0;
        send_uop(FUNC_ALU, tag, 1'b0, other, 1'b1, 5'd7);
        wait_done();
        repeat (`RS_MULT_ENTRIES) begin
            send_uop(FUNC_MULT, tag, 1'b1, other, 1'b1, 5'd8);
        end
        repeat (`RS_BRANCH_ENTRIES) begin
            send_uop(FUNC_BRANCH, tag, 1'b1, other, 1'b1, rob + 1'b1);
        end
        flush_station();
        update = 1'b1;
        ready_reg = tag;
        next_cycle();
        update = 1'b0;
        hold_issue(4);
        finish_test(6, "free and rollback", errors_before);

        $display("tests run: 6, tests with errors: %0d, check errors: %0d",
                 failed_tests, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
